/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

    //////////////////////////////
    // Field types

    typedef logic [4:0] reg_addr_t;

    // Major opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_COP0    = 6'h10
    } opcode_e;

    // Function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        F_SLL   = 6'h00,
        F_SRL   = 6'h02,
        F_JR    = 6'h08,
        F_MFHI  = 6'h10,
        F_MFLO  = 6'h12,
        F_MULTU = 6'h19,
        F_ADDU  = 6'h21,
        F_SUBU  = 6'h23,
        F_AND   = 6'h24,
        F_OR    = 6'h25,
        F_SLT   = 6'h2a
    } funct_e;

    // R-type view, immediate and jump target overlay the low bits
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_e    funct;
    } instr_t;

    // eret under OP_COP0
    localparam logic [5:0] ERET_FUNCT = 6'h18;

endpackage

/* logic/mips_core_pkg.sv */
package mips_core_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,
        WB_HI,
        WB_LO
    } wb_sel_e;

    typedef struct packed {
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    link;
        logic    jr;
        logic    eret;
        logic    reg_write;
        logic    alu_src_imm;
        logic    shift_imm;
        alu_op_e alu_op;
        logic    mult_en;
        wb_sel_e wb_sel;
        logic    dest_rd;
    } ctrl_t;

    localparam word_t                   RESET_PC = 32'h0000_0000;
    localparam mips_isa_pkg::reg_addr_t LINK_REG = 5'd31;
    localparam word_t                   PC_STEP  = 32'd4;

endpackage

/* logic/control_decoder.sv */
module control_decoder (
    input  mips_isa_pkg::instr_t  instr,
    output mips_core_pkg::ctrl_t  ctrl
);

    always_comb begin
        // Start from a nop
        ctrl        = '0;
        ctrl.alu_op = mips_core_pkg::ALU_ADD;
        ctrl.wb_sel = mips_core_pkg::WB_ALU;

        case (instr.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                case (instr.funct)
                    mips_isa_pkg::F_SLL: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                        ctrl.shift_imm = 1'b1;
                        ctrl.alu_op    = mips_core_pkg::ALU_SLL;
                    end
                    mips_isa_pkg::F_SRL: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                        ctrl.shift_imm = 1'b1;
                        ctrl.alu_op    = mips_core_pkg::ALU_SRL;
                    end
                    // No write at all, r31 is only touched by jal
                    mips_isa_pkg::F_JR:    ctrl.jr = 1'b1;
                    mips_isa_pkg::F_MULTU: ctrl.mult_en = 1'b1;
                    mips_isa_pkg::F_MFHI: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                        ctrl.wb_sel    = mips_core_pkg::WB_HI;
                    end
                    mips_isa_pkg::F_MFLO: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                        ctrl.wb_sel    = mips_core_pkg::WB_LO;
                    end
                    mips_isa_pkg::F_ADDU,
                    mips_isa_pkg::F_SUBU,
                    mips_isa_pkg::F_AND,
                    mips_isa_pkg::F_OR,
                    mips_isa_pkg::F_SLT: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                        case (instr.funct)
                            mips_isa_pkg::F_SUBU: ctrl.alu_op = mips_core_pkg::ALU_SUB;
                            mips_isa_pkg::F_AND:  ctrl.alu_op = mips_core_pkg::ALU_AND;
                            mips_isa_pkg::F_OR:   ctrl.alu_op = mips_core_pkg::ALU_OR;
                            mips_isa_pkg::F_SLT:  ctrl.alu_op = mips_core_pkg::ALU_SLT;
                            default:              ctrl.alu_op = mips_core_pkg::ALU_ADD;
                        endcase
                    end
                    default: ;
                endcase
            end
            mips_isa_pkg::OP_J: ctrl.jump = 1'b1;
            mips_isa_pkg::OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = mips_core_pkg::WB_LINK;
            end
            // Branches compare through a subtract
            mips_isa_pkg::OP_BEQ: begin
                ctrl.branch_eq = 1'b1;
                ctrl.alu_op    = mips_core_pkg::ALU_SUB;
            end
            mips_isa_pkg::OP_BNE: begin
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = mips_core_pkg::ALU_SUB;
            end
            mips_isa_pkg::OP_ADDIU: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            mips_isa_pkg::OP_COP0: ctrl.eret = (instr.funct == mips_isa_pkg::ERET_FUNCT);
            default: ;
        endcase
    end

endmodule

/* logic/irq_context.sv */
module irq_context (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 irq_req,
    input  mips_core_pkg::word_t irq_vector,
    input  logic                 eret,
    input  mips_core_pkg::word_t seq_pc,
    output logic                 enter,
    output logic                 resume,
    output mips_core_pkg::word_t resume_pc,
    output mips_core_pkg::word_t irq_vector_q,
    output logic                 irq_ack,
    output logic                 irq_active
);

    // Take a request only once the previous handshake has fully closed
    assign enter  = irq_req && !irq_active && !irq_ack;
    assign resume = eret && irq_active;

    // Entry target, forced to a word boundary
    assign irq_vector_q = {irq_vector[31:2], 2'b00};

    //////////////////////////////
    // Context state

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_active <= 1'b0;
            irq_ack    <= 1'b0;
        end else begin
            if (enter) begin
                irq_active <= 1'b1;
            end else if (resume) begin
                irq_active <= 1'b0;
            end

            // Ack holds until the requester lets go
            if (enter) begin
                irq_ack <= 1'b1;
            end else if (!irq_req) begin
                irq_ack <= 1'b0;
            end
        end
    end

    // Program PC to come back to
    always_ff @(posedge clk) begin
        if (enter) begin
            resume_pc <= seq_pc;
        end
    end

endmodule

/* logic/next_pc_unit.sv */
module next_pc_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_core_pkg::ctrl_t ctrl,
    input  mips_isa_pkg::instr_t instr,
    input  logic                 zero,
    input  mips_core_pkg::word_t rs_data,
    input  logic                 enter,
    input  logic                 resume,
    input  mips_core_pkg::word_t resume_pc,
    input  mips_core_pkg::word_t irq_vector,
    output mips_core_pkg::word_t pc,
    output mips_core_pkg::word_t pc_plus4,
    output mips_core_pkg::word_t seq_pc
);

    mips_core_pkg::word_t sext_imm;
    mips_core_pkg::word_t bta;
    mips_core_pkg::word_t jta;
    mips_core_pkg::word_t pc_next;
    logic                 br_taken;

    //////////////////////////////
    // Targets

    assign pc_plus4 = pc + mips_core_pkg::PC_STEP;
    assign sext_imm = {{16{instr[15]}}, instr[15:0]};
    assign bta      = pc_plus4 + {sext_imm[29:0], 2'b00};
    assign jta      = {pc_plus4[31:28], instr[25:0], 2'b00};

    assign br_taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

    // Where the program itself goes next
    always_comb begin
        if (ctrl.jr) begin
            seq_pc = rs_data;
        end else if (ctrl.jump) begin
            seq_pc = jta;
        end else if (br_taken) begin
            seq_pc = bta;
        end else begin
            seq_pc = pc_plus4;
        end
    end

    // Exception context overrides the program
    assign pc_next = resume ? resume_pc : (enter ? irq_vector : seq_pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= mips_core_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* logic/register_file.sv */
module register_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      we,
    input  mips_isa_pkg::reg_addr_t   wa,
    input  mips_core_pkg::word_t      wd,
    input  mips_isa_pkg::reg_addr_t   ra1,
    input  mips_isa_pkg::reg_addr_t   ra2,
    input  mips_isa_pkg::reg_addr_t   ra3,
    output mips_core_pkg::word_t      rd1,
    output mips_core_pkg::word_t      rd2,
    output mips_core_pkg::word_t      rd3
);

    mips_core_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // r0 is hardwired to zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
    assign rd3 = (ra3 == '0) ? '0 : regs[ra3];

endmodule

/* logic/execute_unit.sv */
module execute_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_core_pkg::ctrl_t      ctrl,
    input  mips_isa_pkg::instr_t      instr,
    input  mips_core_pkg::word_t      rs_data,
    input  mips_core_pkg::word_t      rt_data,
    input  mips_core_pkg::word_t      pc_plus4,
    output logic                      zero,
    output mips_isa_pkg::reg_addr_t   wb_addr,
    output mips_core_pkg::word_t      wb_data
);

    mips_core_pkg::word_t alu_a;
    mips_core_pkg::word_t alu_b;
    mips_core_pkg::word_t alu_y;
    mips_core_pkg::word_t hi;
    mips_core_pkg::word_t lo;
    logic [63:0]          product;

    //////////////////////////////
    // ALU

    assign alu_a = ctrl.shift_imm ? {27'd0, instr.shamt} : rs_data;
    assign alu_b = ctrl.alu_src_imm ? {{16{instr[15]}}, instr[15:0]} : rt_data;

    always_comb begin
        case (ctrl.alu_op)
            mips_core_pkg::ALU_ADD: alu_y = alu_a + alu_b;
            mips_core_pkg::ALU_SUB: alu_y = alu_a - alu_b;
            mips_core_pkg::ALU_AND: alu_y = alu_a & alu_b;
            mips_core_pkg::ALU_OR:  alu_y = alu_a | alu_b;
            mips_core_pkg::ALU_SLT: alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
            // Shift amount sits in operand a
            mips_core_pkg::ALU_SLL: alu_y = alu_b << alu_a[4:0];
            mips_core_pkg::ALU_SRL: alu_y = alu_b >> alu_a[4:0];
            default:                alu_y = '0;
        endcase
    end

    assign zero = (alu_y == '0);

    //////////////////////////////
    // Multiplier

    assign product = {32'd0, rs_data} * {32'd0, rt_data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (ctrl.mult_en) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

    //////////////////////////////
    // Write-back

    always_comb begin
        case (ctrl.wb_sel)
            mips_core_pkg::WB_LINK: wb_data = pc_plus4;
            mips_core_pkg::WB_HI:   wb_data = hi;
            mips_core_pkg::WB_LO:   wb_data = lo;
            default:                wb_data = alu_y;
        endcase
    end

    // jal links into r31, R-type into rd, I-type into rt
    assign wb_addr = ctrl.link    ? mips_core_pkg::LINK_REG :
                     ctrl.dest_rd ? instr.rd : instr.rt;

endmodule

/* logic/mips_core.sv */
module mips_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_isa_pkg::instr_t    instr,
    input  logic                    irq_req,
    input  mips_core_pkg::word_t    irq_vector,
    input  mips_isa_pkg::reg_addr_t dbg_addr,
    output mips_core_pkg::word_t    pc,
    output logic                    irq_ack,
    output logic                    irq_active,
    output mips_core_pkg::word_t    dbg_data
);

    mips_core_pkg::ctrl_t    ctrl;
    mips_core_pkg::word_t    rs_data;
    mips_core_pkg::word_t    rt_data;
    mips_core_pkg::word_t    wb_data;
    mips_core_pkg::word_t    pc_plus4;
    mips_core_pkg::word_t    seq_pc;
    mips_core_pkg::word_t    resume_pc;
    mips_core_pkg::word_t    irq_vector_q;
    mips_isa_pkg::reg_addr_t wb_addr;
    logic                    zero;
    logic                    enter;
    logic                    resume;

    control_decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    irq_context irq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_req      (irq_req),
        .irq_vector   (irq_vector),
        .eret         (ctrl.eret),
        .seq_pc       (seq_pc),
        .enter        (enter),
        .resume       (resume),
        .resume_pc    (resume_pc),
        .irq_vector_q (irq_vector_q),
        .irq_ack      (irq_ack),
        .irq_active   (irq_active)
    );

    next_pc_unit pc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .instr      (instr),
        .zero       (zero),
        .rs_data    (rs_data),
        .enter      (enter),
        .resume     (resume),
        .resume_pc  (resume_pc),
        .irq_vector (irq_vector_q),
        .pc         (pc),
        .pc_plus4   (pc_plus4),
        .seq_pc     (seq_pc)
    );

    // Third read port serves the debug interface
    register_file rf_i (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (ctrl.reg_write),
        .wa    (wb_addr),
        .wd    (wb_data),
        .ra1   (instr.rs),
        .ra2   (instr.rt),
        .ra3   (dbg_addr),
        .rd1   (rs_data),
        .rd2   (rt_data),
        .rd3   (dbg_data)
    );

    execute_unit exe_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .instr    (instr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .pc_plus4 (pc_plus4),
        .zero     (zero),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

/* tb/mips_core_assertions.sv */
module mips_core_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 irq_req,
    input logic                 irq_ack,
    input mips_core_pkg::word_t pc
);

    int fail_count = 0;

    // Ack only answers a request seen on the entry edge
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq_ack) |-> $past(irq_req))
    else begin
        fail_count++;
        $error("irq_ack rose without irq_req");
    end

    // Ack holds as long as the request is up
    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_ack && irq_req) |=> irq_ack)
    else begin
        fail_count++;
        $error("irq_ack dropped while irq_req was high");
    end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("pc not word aligned");
    end

endmodule

bind mips_core mips_core_assertions assertions_i (.*);

/* tb/mips_core_tb.sv */
module mips_core_tb;

    localparam int RESET_CYCLES = 2;
    localparam int ALU_LEN      = 24;
    localparam int ALU_RUN      = ALU_LEN + 4;
    localparam int MUL_RUN      = 12;
    localparam int BR_RUN       = 16;
    localparam int IRQ_RUN      = 20;
    localparam int ACK_WAIT     = 8;
    // Reset hold, reset release and a 32-register dump per test
    localparam int TEST_OVERHEAD = 1 + RESET_CYCLES + 32;
    localparam int CYCLE_LIMIT   = 5 * TEST_OVERHEAD + ALU_RUN + MUL_RUN + BR_RUN
                                   + IRQ_RUN + 2 * ACK_WAIT + 4 + 40;

    localparam mips_core_pkg::word_t VECTOR = 32'h0000_0080;
    localparam logic [31:0] ERET_WORD = {mips_isa_pkg::OP_COP0, 20'h8_0000,
                                         mips_isa_pkg::ERET_FUNCT};

    logic                    clk = 1'b0;
    logic                    rst_n;
    mips_isa_pkg::instr_t    instr;
    logic                    irq_req;
    mips_core_pkg::word_t    irq_vector;
    mips_isa_pkg::reg_addr_t dbg_addr;
    mips_core_pkg::word_t    pc;
    logic                    irq_ack;
    logic                    irq_active;
    mips_core_pkg::word_t    dbg_data;

    logic [31:0] imem [64];
    logic [31:0] lfsr;

    // Architectural model state
    mips_core_pkg::word_t m_regs [32];
    mips_core_pkg::word_t m_hi;
    mips_core_pkg::word_t m_lo;
    mips_core_pkg::word_t m_pc;
    mips_core_pkg::word_t m_saved;
    logic                 m_active;
    logic                 m_ack;
    logic                 model_on;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    always #2 clk = ~clk;

    // Instruction memory answers in the same cycle
    assign instr = mips_isa_pkg::instr_t'(imem[pc[7:2]]);

    mips_core dut_i (.*);

    //////////////////////////////
    // Stimulus helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] r_format(input mips_isa_pkg::funct_e f,
                                             input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sh);
        return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, sh, f};
    endfunction

    function automatic logic [31:0] i_format(input mips_isa_pkg::opcode_e op,
                                             input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_format(input mips_isa_pkg::opcode_e op,
                                             input logic [25:0] target);
        return {op, target};
    endfunction

    // Every word jumps to itself, so a program parks where it runs off its end
    function automatic void fill_memory();
        for (int k = 0; k < 64; k++) begin
            imem[k] = j_format(mips_isa_pkg::OP_J, 26'(k));
        end
    endfunction

    //////////////////////////////
    // Reference model

    function automatic void model_step(input logic req, input mips_core_pkg::word_t vec);
        mips_isa_pkg::instr_t    i;
        mips_core_pkg::word_t    a;
        mips_core_pkg::word_t    b;
        mips_core_pkg::word_t    imm;
        mips_core_pkg::word_t    nxt;
        mips_core_pkg::word_t    res;
        mips_isa_pkg::reg_addr_t wa;
        logic [63:0]             prod;
        logic                    wr;
        logic                    ret;
        logic                    take;
        i   = mips_isa_pkg::instr_t'(imem[m_pc[7:2]]);
        a   = m_regs[i.rs];
        b   = m_regs[i.rt];
        imm = {{16{i[15]}}, i[15:0]};
        nxt = m_pc + 32'd4;
        res = '0;
        wa  = i.rd;
        wr  = 1'b0;
        ret = 1'b0;
        case (i.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                wr = 1'b1;
                case (i.funct)
                    mips_isa_pkg::F_SLL:  res = b << i.shamt;
                    mips_isa_pkg::F_SRL:  res = b >> i.shamt;
                    mips_isa_pkg::F_ADDU: res = a + b;
                    mips_isa_pkg::F_SUBU: res = a - b;
                    mips_isa_pkg::F_AND:  res = a & b;
                    mips_isa_pkg::F_OR:   res = a | b;
                    mips_isa_pkg::F_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    mips_isa_pkg::F_MFHI: res = m_hi;
                    mips_isa_pkg::F_MFLO: res = m_lo;
                    mips_isa_pkg::F_JR: begin
                        wr  = 1'b0;
                        nxt = a;
                    end
                    mips_isa_pkg::F_MULTU: begin
                        wr   = 1'b0;
                        prod = {32'd0, a} * {32'd0, b};
                        m_hi = prod[63:32];
                        m_lo = prod[31:0];
                    end
                    default: wr = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_J: nxt = {nxt[31:28], i[25:0], 2'b00};
            mips_isa_pkg::OP_JAL: begin
                wr  = 1'b1;
                wa  = mips_core_pkg::LINK_REG;
                res = nxt;
                nxt = {nxt[31:28], i[25:0], 2'b00};
            end
            mips_isa_pkg::OP_BEQ: if (a == b) nxt = nxt + {imm[29:0], 2'b00};
            mips_isa_pkg::OP_BNE: if (a != b) nxt = nxt + {imm[29:0], 2'b00};
            mips_isa_pkg::OP_ADDIU: begin
                wr  = 1'b1;
                wa  = i.rt;
                res = a + imm;
            end
            mips_isa_pkg::OP_COP0: ret = (i[5:0] == mips_isa_pkg::ERET_FUNCT);
            default: ;
        endcase
        if (wr && wa != 5'd0) m_regs[wa] = res;

        // Exception context, four-phase request rule
        ret  = ret && m_active;
        take = req && !m_active && !m_ack;
        if (ret) begin
            nxt      = m_saved;
            m_active = 1'b0;
        end else if (take) begin
            m_saved  = nxt;
            nxt      = {vec[31:2], 2'b00};
            m_active = 1'b1;
        end
        if (take) m_ack = 1'b1;
        else if (!req) m_ack = 1'b0;
        m_pc = nxt;
    endfunction

    always @(posedge clk) begin
        if (model_on) begin
            model_step(irq_req, irq_vector);
        end
    end

    //////////////////////////////
    // Compare

    task automatic check_pc(input mips_core_pkg::word_t got, input mips_core_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH pc: got %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_reg(input mips_isa_pkg::reg_addr_t a,
                             input mips_core_pkg::word_t got, input mips_core_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH dbg_data r%0d: got %h, expected %h", a, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (model_on) begin
            check_pc(pc, m_pc);
            check_flag("irq_ack", irq_ack, m_ack);
            check_flag("irq_active", irq_active, m_active);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Test sequence

    task automatic hold_reset();
        model_on = 1'b0;
        @(negedge clk);
        rst_n   = 1'b0;
        irq_req = 1'b0;
        fill_memory();
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        m_hi     = '0;
        m_lo     = '0;
        m_pc     = mips_core_pkg::RESET_PC;
        m_saved  = '0;
        m_active = 1'b0;
        m_ack    = 1'b0;
        rst_n    = 1'b1;
        model_on = 1'b1;
    endtask

    task automatic dump_regs();
        for (int r = 0; r < 32; r++) begin
            dbg_addr = 5'(r);
            @(negedge clk);
            check_reg(5'(r), dbg_data, m_regs[r]);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        $display("%-8s %s, %0d errors", name, (errors == e0) ? "ok" : "bad", errors - e0);
    endtask

    task automatic run_reset_test();
        int e0;
        e0 = errors;
        hold_reset();
        release_reset();
        check_pc(pc, mips_core_pkg::RESET_PC);
        check_flag("irq_ack", irq_ack, 1'b0);
        check_flag("irq_active", irq_active, 1'b0);
        dump_regs();
        report_test("reset", e0);
    endtask

    task automatic run_alu_test();
        int         e0;
        logic [2:0] sel;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        e0 = errors;
        hold_reset();
        // First few are addiu so the registers hold something
        for (int k = 0; k < ALU_LEN; k++) begin
            sel = (k < 4) ? 3'd0 : 3'(rand_bits(3));
            rs  = 5'(rand_bits(3));
            rt  = 5'(rand_bits(3));
            rd  = 5'(rand_bits(3));
            case (sel)
                3'd0: imem[k] = i_format(mips_isa_pkg::OP_ADDIU, rs, rt, 16'(rand_bits(16)));
                3'd1: imem[k] = r_format(mips_isa_pkg::F_ADDU, rs, rt, rd, 5'd0);
                3'd2: imem[k] = r_format(mips_isa_pkg::F_SUBU, rs, rt, rd, 5'd0);
                3'd3: imem[k] = r_format(mips_isa_pkg::F_AND, rs, rt, rd, 5'd0);
                3'd4: imem[k] = r_format(mips_isa_pkg::F_OR, rs, rt, rd, 5'd0);
                3'd5: imem[k] = r_format(mips_isa_pkg::F_SLT, rs, rt, rd, 5'd0);
                3'd6: imem[k] = r_format(mips_isa_pkg::F_SLL, 5'd0, rt, rd, 5'(rand_bits(5)));
                default: imem[k] = r_format(mips_isa_pkg::F_SRL, 5'd0, rt, rd, 5'(rand_bits(5)));
            endcase
        end
        release_reset();
        repeat (ALU_RUN) @(negedge clk);
        dump_regs();
        report_test("alu", e0);
    endtask

    task automatic run_mul_test();
        int e0;
        e0 = errors;
        hold_reset();
        // Build two full 32-bit operands from halves
        imem[0] = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'(rand_bits(16)));
        imem[1] = r_format(mips_isa_pkg::F_SLL, 5'd0, 5'd1, 5'd1, 5'd16);
        imem[2] = i_format(mips_isa_pkg::OP_ADDIU, 5'd1, 5'd1, 16'(rand_bits(16)));
        imem[3] = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd2, 16'(rand_bits(16)));
        imem[4] = r_format(mips_isa_pkg::F_SLL, 5'd0, 5'd2, 5'd2, 5'd16);
        imem[5] = i_format(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'(rand_bits(16)));
        imem[6] = r_format(mips_isa_pkg::F_MULTU, 5'd1, 5'd2, 5'd0, 5'd0);
        imem[7] = r_format(mips_isa_pkg::F_MFHI, 5'd0, 5'd0, 5'd3, 5'd0);
        imem[8] = r_format(mips_isa_pkg::F_MFLO, 5'd0, 5'd0, 5'd4, 5'd0);
        release_reset();
        repeat (MUL_RUN) @(negedge clk);
        dump_regs();
        report_test("multu", e0);
    endtask

    task automatic run_branch_test();
        int e0;
        e0 = errors;
        hold_reset();
        imem[0]  = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd5);
        imem[1]  = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd2, 16'd5);
        imem[2]  = i_format(mips_isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1);
        imem[3]  = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd3, 16'd1);
        imem[4]  = i_format(mips_isa_pkg::OP_BNE, 5'd1, 5'd2, 16'd1);
        imem[5]  = i_format(mips_isa_pkg::OP_BEQ, 5'd1, 5'd0, 16'd1);
        imem[6]  = j_format(mips_isa_pkg::OP_JAL, 26'd9);
        imem[7]  = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd6, 16'd7);
        imem[8]  = j_format(mips_isa_pkg::OP_J, 26'd12);
        imem[9]  = i_format(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd5, 16'd3);
        imem[10] = r_format(mips_isa_pkg::F_JR, 5'd31, 5'd0, 5'd0, 5'd0);
        imem[12] = i_format(mips_isa_pkg::OP_BNE, 5'd1, 5'd0, 16'd2);
        release_reset();
        repeat (BR_RUN) @(negedge clk);
        dump_regs();
        report_test("branch", e0);
    endtask

    task automatic run_irq_test();
        int e0;
        int waited;
        e0 = errors;
        hold_reset();
        // Main program with a stray eret, handler at the vector
        imem[0] = i_format(mips_isa_pkg::OP_ADDIU, 5'd1, 5'd1, 16'd1);
        imem[1] = ERET_WORD;
        for (int k = 2; k < 8; k++) begin
            imem[k] = i_format(mips_isa_pkg::OP_ADDIU, 5'd1, 5'd1, 16'd1);
        end
        for (int k = 32; k < 35; k++) begin
            imem[k] = i_format(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd1);
        end
        imem[35] = ERET_WORD;
        release_reset();
        repeat (2) @(negedge clk);
        irq_req = 1'b1;
        waited  = 0;
        while (!irq_ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!irq_ack) begin
            errors++;
            $display("No irq_ack within %0d cycles of the request", ACK_WAIT);
        end
        // Request stays up one cycle past the ack before it drops
        @(negedge clk);
        irq_req = 1'b0;
        waited  = 0;
        while (irq_ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (irq_ack) begin
            errors++;
            $display("irq_ack still high %0d cycles after the request dropped", ACK_WAIT);
        end
        // Second request while the handler is still running
        irq_req = 1'b1;
        @(negedge clk);
        irq_req = 1'b0;
        repeat (IRQ_RUN) @(negedge clk);
        check_flag("irq_active", irq_active, 1'b0);
        dump_regs();
        report_test("irq", e0);
    endtask

    initial begin
        int total;
        model_on   = 1'b0;
        lfsr       = 32'd2;
        rst_n      = 1'b0;
        irq_req    = 1'b0;
        irq_vector = VECTOR;
        dbg_addr   = '0;
        fill_memory();
        run_reset_test();
        run_alu_test();
        run_mul_test();
        run_branch_test();
        run_irq_test();
        total = errors + dut_i.assertions_i.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 dut_i.assertions_i.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
logic/mips_isa_pkg.sv
logic/mips_core_pkg.sv
logic/control_decoder.sv
logic/irq_context.sv
logic/next_pc_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/mips_core.sv
tb/mips_core_assertions.sv
tb/mips_core_tb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - logic/mips_isa_pkg.sv
  - logic/mips_core_pkg.sv
  - logic/control_decoder.sv
  - logic/irq_context.sv
  - logic/next_pc_unit.sv
  - logic/register_file.sv
  - logic/execute_unit.sv
  - logic/mips_core.sv
  - target: test
    files:
      - tb/mips_core_assertions.sv
      - tb/mips_core_tb.sv
